//--- verilog/cache_defines.svh
// cache geometry for a 16-bit CPU bus, widths must agree (tag + index + word + byte = address)
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

////////////////////////////// bus widths
`define CACHE_ADDR_W		32		// CPU and DRAM byte address
`define CACHE_DATA_W		16		// one bus word

////////////////////////////// line geometry
`define CACHE_WORD_W		3		// word select inside a line, address bits 3..1
`define CACHE_LINE_WORDS	8		// words per line
`define CACHE_INDEX_LO		4		// index starts above the line offset
`define CACHE_INDEX_W		5		// address bits 8..4
`define CACHE_LINES			32		// direct mapped, one line per index
`define CACHE_TAG_LO		9		// tag starts above the index
`define CACHE_TAG_W			23		// address bits 31..9

////////////////////////////// DRAM timing
`define CACHE_CAS_LATENCY	2		// cycles after CAS sampled low, must be 1 or more

`endif

//--- verilog/cachePkg.sv
// shared cache types, field widths follow cache_defines.svh and the state enum must fit 4 bits
`default_nettype none

`include "cache_defines.svh"

package cachePkg;

	typedef logic [`CACHE_ADDR_W-1:0]	addr_t;		// byte address
	typedef logic [`CACHE_DATA_W-1:0]	word_t;		// data word
	typedef logic [`CACHE_TAG_W-1:0]	tag_t;		// upper address bits kept per line
	typedef logic [`CACHE_INDEX_W-1:0]	index_t;	// line number
	typedef logic [`CACHE_WORD_W-1:0]	wordSel_t;	// word inside a line

	typedef enum logic [3:0]
	{
		ResetSweep,			// one cycle to clear the counter
		InvalidateLines,	// clear one valid bit per cycle
		Idle,				// wait for a DRAM bus cycle
		CheckHit,			// tag compare result is ready here
		HoldHitData,		// dtack low until the strobe rises
		StartFill,			// select DRAM, wait for a read CAS
		CasWait,			// count out the CAS latency
		BurstFill,			// store one word per cycle
		EndFill,			// hand the requested word to the CPU
		WriteThrough		// relay the write and its acknowledge
	} cacheState_t;

endpackage

`default_nettype wire

//--- verilog/tagValidStore.sv
// tag and valid memory with registered read, hit lags lineIndex by one cycle and valid bits need the sweep
`default_nettype none

`include "cache_defines.svh"

module tagValidStore import cachePkg::*;
(
	input	wire logic		Clock,
	input	wire logic		Reset_L,		// async, active low

	input	wire index_t	lineIndex,		// read and write address
	input	wire tag_t		cpuTag,			// tag to store and to compare

	input	wire logic		tagWrite,
	input	wire logic		validWrite,
	input	wire logic		validValue,

	output	logic			hit				// registered tag matches and line valid
);

	tag_t					tagMem [`CACHE_LINES];		// one tag per line
	logic [`CACHE_LINES-1:0]	validBits;				// cleared by the controller sweep

	tag_t					tagRead;		// tag at last cycle's index
	tag_t					cpuTagRead;		// CPU tag of the same cycle
	logic					validRead;

	////////////////////////////// memories

	always_ff @(posedge Clock)
	begin
		if (tagWrite)
			tagMem[lineIndex] <= cpuTag;
		if (validWrite)
			validBits[lineIndex] <= validValue;
	end

	////////////////////////////// registered read

	always_ff @(posedge Clock)
	begin
		tagRead <= tagMem[lineIndex];		// old contents on a same-cycle write
		cpuTagRead <= cpuTag;
	end

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
			validRead <= 1'b0;				// no hit straight out of reset
		else
			validRead <= validBits[lineIndex];
	end

	assign hit = validRead && (tagRead == cpuTagRead);

	////////////////////////////// checks

	// a freshly written line hits once the read register catches up
	assert property (@(posedge Clock) disable iff (!Reset_L)
		(tagWrite && validWrite && validValue)
		##1 (!tagWrite && !validWrite && $stable(lineIndex) && $stable(cpuTag))
		|=> hit);

endmodule

`default_nettype wire

//--- verilog/dataStore.sv
// line data memory, one write port and an asynchronous read, so it maps to distributed RAM
`default_nettype none

`include "cache_defines.svh"

module dataStore import cachePkg::*;
(
	input	wire logic		Clock,

	input	wire index_t	lineIndex,		// line being read or filled
	input	wire wordSel_t	wordSel,		// word inside the line

	input	wire logic		dataWrite,		// store dramDataIn this edge
	input	wire word_t		dramDataIn,

	output	word_t			lineData		// selected word, combinational
);

	localparam int depth = `CACHE_LINES * `CACHE_LINE_WORDS;	// 256 words

	word_t								dataMem [depth];
	logic [`CACHE_INDEX_W+`CACHE_WORD_W-1:0]	wordAddress;	// line then word

	assign wordAddress = {lineIndex, wordSel};

	////////////////////////////// write port

	always_ff @(posedge Clock)
	begin
		if (dataWrite)
			dataMem[wordAddress] <= dramDataIn;		// one burst word per cycle
	end

	////////////////////////////// read port

	assign lineData = dataMem[wordAddress];		// follows wordSel in the same cycle

endmodule

`default_nettype wire

//--- verilog/cacheController.sv
// sequencing FSM, CPU must hold address and data until cpuAs_L rises, burst words arrive back to back
`default_nettype none

`include "cache_defines.svh"

module cacheController import cachePkg::*;
(
	input	wire logic		Clock,
	input	wire logic		Reset_L,		// async, active low

	input	wire addr_t		cpuAddress,		// held for the whole bus cycle
	input	wire logic		cpuAs_L,
	input	wire logic		cpuUds_L,
	input	wire logic		cpuLds_L,
	input	wire logic		cpuWe_L,		// low for a write
	input	wire logic		cpuDramSelect,	// high when the CPU addresses DRAM

	input	wire logic		hit,			// compare of the previous cycle's index
	input	wire logic		dramCas_L,
	input	wire logic		dramRas_L,		// low together with CAS means refresh
	input	wire logic		dramDtack_L,

	output	logic			cpuDtack_L,
	output	addr_t			dramAddress,
	output	logic			dramSelect_L,
	output	logic			dramAs_L,
	output	logic			dramWe_L,
	output	logic			dramUds_L,
	output	logic			dramLds_L,

	output	index_t			lineIndex,		// to both stores
	output	wordSel_t		wordSel,		// to the data store
	output	logic			tagWrite,
	output	logic			validWrite,
	output	logic			validValue,
	output	logic			dataWrite
);

	localparam index_t lastLine = index_t'(`CACHE_LINES - 1);			// end of the sweep
	localparam index_t lastWord = index_t'(`CACHE_LINE_WORDS - 1);		// end of a burst
	localparam index_t casLast = index_t'(`CACHE_CAS_LATENCY - 1);		// end of CAS wait

	cacheState_t	state;
	cacheState_t	nextState;
	index_t			burstCount;		// line number in the sweep, then latency and word count
	logic			burstClear;		// restart the count next cycle
	logic			cycleStart;		// CPU has begun a DRAM bus cycle
	index_t			cpuIndex;
	wordSel_t		cpuWord;
	addr_t			lineAddress;	// CPU address aligned to the line

	assign cycleStart = !cpuAs_L && cpuDramSelect;
	assign cpuIndex = cpuAddress[`CACHE_INDEX_LO +: `CACHE_INDEX_W];
	assign cpuWord = cpuAddress[1 +: `CACHE_WORD_W];		// bit 0 is the byte lane
	assign lineAddress = {cpuAddress[`CACHE_ADDR_W-1:`CACHE_INDEX_LO], {`CACHE_INDEX_LO{1'b0}}};

	////////////////////////////// state and counter registers

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
			state <= ResetSweep;
		else
			state <= nextState;
	end

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
			burstCount <= '0;
		else if (burstClear)
			burstCount <= '0;
		else
			burstCount <= burstCount + index_t'(1);		// wraps, only compared where bounded
	end

	////////////////////////////// next state and outputs

	always_comb
	begin
		nextState = state;
		burstClear = 1'b0;

		cpuDtack_L = 1'b1;			// CPU stalls until a state says otherwise
		dramAddress = lineAddress;	// fills always start at word 0
		dramSelect_L = 1'b1;
		dramAs_L = cpuAs_L;
		dramWe_L = cpuWe_L;
		dramUds_L = cpuUds_L;		// CPU strobes pass through for writes
		dramLds_L = cpuLds_L;

		lineIndex = cpuIndex;
		wordSel = cpuWord;
		tagWrite = 1'b0;
		validWrite = 1'b0;
		validValue = 1'b0;
		dataWrite = 1'b0;

		case (state)
			ResetSweep:
			begin
				burstClear = 1'b1;				// sweep starts at line 0
				nextState = InvalidateLines;
			end

			InvalidateLines:
			begin
				lineIndex = burstCount;			// walk every line
				validWrite = 1'b1;				// validValue stays 0
				if (burstCount == lastLine)
					nextState = Idle;
			end

			Idle:
			begin
				if (cycleStart)
					nextState = cpuWe_L ? CheckHit : WriteThrough;
			end

			CheckHit:
			begin
				dramUds_L = 1'b0;				// reads always fetch both bytes
				dramLds_L = 1'b0;
				if (hit)
				begin
					cpuDtack_L = 1'b0;			// word is already on lineData
					nextState = HoldHitData;
				end
				else
					nextState = StartFill;
			end

			HoldHitData:
			begin
				dramUds_L = 1'b0;
				dramLds_L = 1'b0;
				cpuDtack_L = 1'b0;
				if (cpuAs_L)
					nextState = Idle;			// CPU ended the cycle
			end

			StartFill:
			begin
				dramUds_L = 1'b0;
				dramLds_L = 1'b0;
				dramSelect_L = 1'b0;
				burstClear = 1'b1;				// latency counts from the CAS sample
				if (!dramCas_L && dramRas_L)	// read CAS, refresh ignored
					nextState = CasWait;
			end

			CasWait:
			begin
				dramUds_L = 1'b0;
				dramLds_L = 1'b0;
				dramSelect_L = 1'b0;
				if (burstCount == casLast)
				begin
					burstClear = 1'b1;			// count words from 0
					nextState = BurstFill;
				end
			end

			BurstFill:
			begin
				dramUds_L = 1'b0;
				dramLds_L = 1'b0;
				dramSelect_L = 1'b0;
				wordSel = burstCount[`CACHE_WORD_W-1:0];
				dataWrite = 1'b1;				// one word lands per cycle
				if (burstCount == lastWord)
				begin
					// line turns valid together with its last word
					tagWrite = 1'b1;
					validWrite = 1'b1;
					validValue = 1'b1;
					nextState = EndFill;
				end
			end

			EndFill:
			begin
				dramUds_L = 1'b0;
				dramLds_L = 1'b0;
				cpuDtack_L = 1'b0;				// requested word from the filled line
				if (cpuAs_L)
					nextState = Idle;
			end

			WriteThrough:
			begin
				dramAddress = cpuAddress;		// exact byte address
				dramSelect_L = cpuAs_L;			// released as soon as the CPU lets go
				cpuDtack_L = dramDtack_L;		// relay the DRAM acknowledge
				validWrite = hit;				// drop a stale cached copy
				if (cpuAs_L)
					nextState = Idle;
			end

			default:
				nextState = ResetSweep;
		endcase
	end

	////////////////////////////// checks

	// data store is only loaded from an active DRAM read inside the CPU's read cycle
	assert property (@(posedge Clock) disable iff (!Reset_L)
		dataWrite |-> !dramSelect_L && dramWe_L && !cpuAs_L && cpuDramSelect);

	// a new tag goes in valid, and only at the end of a whole line of data writes
	assert property (@(posedge Clock) disable iff (!Reset_L)
		tagWrite |-> validWrite && validValue && $past(dataWrite, `CACHE_LINE_WORDS - 1));

endmodule

`default_nettype wire

//--- verilog/cacheTop.sv
// read cache top, writes go straight through and the DRAM device with its controller sits outside
`default_nettype none

`include "cache_defines.svh"

module cacheTop import cachePkg::*;
(
	input	wire logic		Clock,
	input	wire logic		Reset_L,		// async, active low

	////////////////////////////// CPU side
	input	wire addr_t		cpuAddress,
	input	wire word_t		cpuDataIn,		// write data
	input	wire logic		cpuAs_L,
	input	wire logic		cpuUds_L,		// byte lane 15..8
	input	wire logic		cpuLds_L,		// byte lane 7..0
	input	wire logic		cpuWe_L,
	input	wire logic		cpuDramSelect,
	output	word_t			cpuDataOut,		// read data from the cache
	output	logic			cpuDtack_L,

	////////////////////////////// DRAM side
	output	addr_t			dramAddress,
	output	word_t			dramDataOut,
	output	logic			dramSelect_L,
	output	logic			dramAs_L,
	output	logic			dramWe_L,
	output	logic			dramUds_L,
	output	logic			dramLds_L,
	input	wire word_t		dramDataIn,		// burst data
	input	wire logic		dramDtack_L,
	input	wire logic		dramCas_L,
	input	wire logic		dramRas_L
);

	index_t		lineIndex;
	wordSel_t	wordSel;
	tag_t		cpuTag;
	logic		tagWrite;
	logic		validWrite;
	logic		validValue;
	logic		dataWrite;
	logic		hit;
	word_t		lineData;

	assign cpuTag = cpuAddress[`CACHE_TAG_LO +: `CACHE_TAG_W];
	assign dramDataOut = cpuDataIn;		// write data needs no buffering
	assign cpuDataOut = lineData;		// reads always come from the cache

	cacheController controller
	(
		.Clock			(Clock),
		.Reset_L		(Reset_L),
		.cpuAddress		(cpuAddress),
		.cpuAs_L		(cpuAs_L),
		.cpuUds_L		(cpuUds_L),
		.cpuLds_L		(cpuLds_L),
		.cpuWe_L		(cpuWe_L),
		.cpuDramSelect	(cpuDramSelect),
		.hit			(hit),
		.dramCas_L		(dramCas_L),
		.dramRas_L		(dramRas_L),
		.dramDtack_L	(dramDtack_L),
		.cpuDtack_L		(cpuDtack_L),
		.dramAddress	(dramAddress),
		.dramSelect_L	(dramSelect_L),
		.dramAs_L		(dramAs_L),
		.dramWe_L		(dramWe_L),
		.dramUds_L		(dramUds_L),
		.dramLds_L		(dramLds_L),
		.lineIndex		(lineIndex),
		.wordSel		(wordSel),
		.tagWrite		(tagWrite),
		.validWrite		(validWrite),
		.validValue		(validValue),
		.dataWrite		(dataWrite)
	);

	tagValidStore tagStore
	(
		.Clock			(Clock),
		.Reset_L		(Reset_L),
		.lineIndex		(lineIndex),
		.cpuTag			(cpuTag),
		.tagWrite		(tagWrite),
		.validWrite		(validWrite),
		.validValue		(validValue),
		.hit			(hit)
	);

	dataStore dataMem
	(
		.Clock			(Clock),
		.lineIndex		(lineIndex),
		.wordSel		(wordSel),
		.dataWrite		(dataWrite),
		.dramDataIn		(dramDataIn),
		.lineData		(lineData)
	);

endmodule

`default_nettype wire

//--- tb/tbClockGen.sv
// testbench clock and power-on reset, reset releases a short delay after a rising edge
`default_nettype none

module tbClockGen
#(
	parameter int	period = 100,
	parameter int	resetCycles = 2,		// rising edges seen with reset low
	parameter int	releaseDelay = 10
)
(
	output	logic	Clock,
	output	logic	Reset_L
);

	initial
	begin
		Clock = 1'b0;
		forever
			#(period / 2) Clock = ~Clock;
	end

	initial
	begin
		Reset_L = 1'b0;
		repeat (resetCycles)
			@(posedge Clock);
		#(releaseDelay);
		Reset_L = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/tbDramModel.sv
// behavioral DRAM and controller, 64K words so byte address bits above 16 alias
`default_nettype none

`include "cache_defines.svh"

module tbDramModel import cachePkg::*;
#(
	parameter int		casLatency = `CACHE_CAS_LATENCY,
	parameter int		writeAckDelay = 2,		// cycles from select to acknowledge
	parameter int		driveDelay = 10,		// outputs change after the rising edge
	parameter integer	fillSeed = 32'h3c88_eb78
)
(
	input	wire logic		Clock,
	input	wire addr_t		dramAddress,
	input	wire word_t		dramDataOut,
	input	wire logic		dramSelect_L,
	input	wire logic		dramWe_L,
	input	wire logic		dramUds_L,
	input	wire logic		dramLds_L,
	output	word_t			dramDataIn,
	output	logic			dramDtack_L,
	output	logic			dramCas_L,
	output	logic			dramRas_L,
	output	int				burstCount,			// read bursts started so far
	output	addr_t			lastBurstAddress
);

	localparam int memWords = 65536;

	word_t	mem [memWords];		// word address is byte address bits 16..1

	initial
	begin : fillMemory
		integer seed;
		seed = fillSeed;
		for (int i = 0; i < memWords; i++)
			mem[i] = word_t'($random(seed));
	end

	////////////////////////////// bus timing

	initial
	begin : busCycle
		logic			selected;
		logic			reading;
		addr_t			sampledAddress;
		word_t			sampledData;
		logic			sampledUds_L;
		logic			sampledLds_L;
		logic			bursting;
		logic			busy;			// burst done, waiting for select to drop
		logic			refreshDue;
		int				step;			// cycles since the read CAS
		int				writeWait;
		logic [15:0]	baseWord;
		word_t			merged;

		dramDataIn = '0;
		dramDtack_L = 1'b1;
		dramCas_L = 1'b1;
		dramRas_L = 1'b1;
		burstCount = 0;
		lastBurstAddress = '0;
		bursting = 1'b0;
		busy = 1'b0;
		refreshDue = 1'b1;			// first fill sees a refresh ahead of its CAS
		step = 0;
		writeWait = 0;
		baseWord = '0;
		forever
		begin
			@(negedge Clock);						// cache outputs settled mid cycle
			selected = !dramSelect_L;
			reading = dramWe_L;
			sampledAddress = dramAddress;
			sampledData = dramDataOut;
			sampledUds_L = dramUds_L;
			sampledLds_L = dramLds_L;
			@(posedge Clock);
			#(driveDelay);
			dramCas_L = 1'b1;
			dramRas_L = 1'b1;
			if (!selected)
			begin
				busy = 1'b0;
				writeWait = 0;
				dramDtack_L = 1'b1;
			end
			if (bursting)
			begin
				step++;
				if (step > casLatency)
					dramDataIn = mem[baseWord + 16'(step - casLatency - 1)];	// word k at cycle lat+1+k
				if (step == casLatency + `CACHE_LINE_WORDS)
					bursting = 1'b0;
			end
			else if (selected && reading && !busy)
			begin
				dramCas_L = 1'b0;
				if (refreshDue)
				begin
					dramRas_L = 1'b0;				// refresh, no data follows
					refreshDue = 1'b0;
				end
				else
				begin
					bursting = 1'b1;				// this is cycle 0
					busy = 1'b1;
					step = 0;
					baseWord = sampledAddress[16:1];
					lastBurstAddress = sampledAddress;
					burstCount++;
					refreshDue = (burstCount % 3) == 0;
				end
			end
			else if (selected && !reading)
			begin
				writeWait++;
				if (writeWait >= writeAckDelay && dramDtack_L)
				begin
					merged = mem[sampledAddress[16:1]];
					if (!sampledUds_L)
						merged[15:8] = sampledData[15:8];	// upper lane
					if (!sampledLds_L)
						merged[7:0] = sampledData[7:0];
					mem[sampledAddress[16:1]] = merged;
					dramDtack_L = 1'b0;				// held until select drops
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/cacheTop_tb.sv
// directed cache tests, addresses stay below 128 KB so the DRAM model never aliases
`default_nettype none

`include "cache_defines.svh"

module cacheTop_tb import cachePkg::*;
();

	localparam int		clockPeriod = 100;
	localparam int		driveDelay = 10;			// CPU inputs change after the rising edge
	localparam int		memWords = 65536;
	localparam int		randomOps = 200;
	localparam int		cpuCycles = 11 + randomOps;	// bus cycles over all tests
	localparam int		timeoutTime = cpuCycles * 200 * clockPeriod;
	localparam integer	fillSeed = 32'h3c88_eb78;

	logic		Clock;
	logic		Reset_L;
	addr_t		cpuAddress;
	word_t		cpuDataIn;
	logic		cpuAs_L;
	logic		cpuUds_L;
	logic		cpuLds_L;
	logic		cpuWe_L;
	logic		cpuDramSelect;
	word_t		cpuDataOut;
	logic		cpuDtack_L;
	addr_t		dramAddress;
	word_t		dramDataOut;
	logic		dramSelect_L;
	logic		dramAs_L;
	logic		dramWe_L;
	logic		dramUds_L;
	logic		dramLds_L;
	word_t		dramDataIn;
	logic		dramDtack_L;
	logic		dramCas_L;
	logic		dramRas_L;
	int			burstCount;
	addr_t		lastBurstAddress;

	word_t						refMem [memWords];		// expected DRAM contents
	tag_t						shadowTag [`CACHE_LINES];
	logic [`CACHE_LINES-1:0]	shadowValid;
	integer						seed;
	int							errorCount = 0;

	tbClockGen #(.period(clockPeriod), .resetCycles(2), .releaseDelay(driveDelay)) clockGen
	(
		.Clock			(Clock),
		.Reset_L		(Reset_L)
	);

	tbDramModel #(.driveDelay(driveDelay), .fillSeed(fillSeed)) dram
	(
		.Clock				(Clock),
		.dramAddress		(dramAddress),
		.dramDataOut		(dramDataOut),
		.dramSelect_L		(dramSelect_L),
		.dramWe_L			(dramWe_L),
		.dramUds_L			(dramUds_L),
		.dramLds_L			(dramLds_L),
		.dramDataIn			(dramDataIn),
		.dramDtack_L		(dramDtack_L),
		.dramCas_L			(dramCas_L),
		.dramRas_L			(dramRas_L),
		.burstCount			(burstCount),
		.lastBurstAddress	(lastBurstAddress)
	);

	cacheTop dut
	(
		.Clock(Clock), .Reset_L(Reset_L),
		.cpuAddress(cpuAddress), .cpuDataIn(cpuDataIn), .cpuAs_L(cpuAs_L),
		.cpuUds_L(cpuUds_L), .cpuLds_L(cpuLds_L), .cpuWe_L(cpuWe_L),
		.cpuDramSelect(cpuDramSelect), .cpuDataOut(cpuDataOut), .cpuDtack_L(cpuDtack_L),
		.dramAddress(dramAddress), .dramDataOut(dramDataOut), .dramSelect_L(dramSelect_L),
		.dramAs_L(dramAs_L), .dramWe_L(dramWe_L), .dramUds_L(dramUds_L),
		.dramLds_L(dramLds_L), .dramDataIn(dramDataIn), .dramDtack_L(dramDtack_L),
		.dramCas_L(dramCas_L), .dramRas_L(dramRas_L)
	);

	////////////////////////////// helpers

	task automatic failRun(input string line);
		errorCount++;
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at the first failure");
	endtask

	function automatic addr_t makeAddress(input tag_t tag, input index_t index, input wordSel_t word);
		return {tag, index, word, 1'b0};		// byte bit 0 clear
	endfunction

	// one CPU read cycle, checked against refMem and the shadow tags
	task automatic readWord(input addr_t address, output int bursts);
		index_t		index;
		tag_t		tag;
		logic		expectMiss;
		int			burstsBefore;
		int			waitCycles;
		word_t		got;
		word_t		expected;
		addr_t		lineBase;

		index = address[`CACHE_INDEX_LO +: `CACHE_INDEX_W];
		tag = address[`CACHE_TAG_LO +: `CACHE_TAG_W];
		expectMiss = !(shadowValid[index] && shadowTag[index] == tag);
		expected = refMem[address[16:1]];
		lineBase = address;
		lineBase[`CACHE_INDEX_LO-1:0] = '0;
		burstsBefore = burstCount;
		@(posedge Clock);
		#(driveDelay);
		cpuAddress = address;
		cpuWe_L = 1'b1;
		cpuUds_L = 1'b0;
		cpuLds_L = 1'b0;
		cpuDramSelect = 1'b1;
		cpuAs_L = 1'b0;
		waitCycles = 0;
		do
		begin
			@(negedge Clock);						// sample where outputs are stable
			waitCycles++;
		end
		while (cpuDtack_L);
		got = cpuDataOut;
		@(posedge Clock);
		#(driveDelay);
		cpuAs_L = 1'b1;
		cpuDramSelect = 1'b0;
		cpuUds_L = 1'b1;
		cpuLds_L = 1'b1;
		bursts = burstCount - burstsBefore;
		assert (got === expected)
		else
			failRun($sformatf("Fail at %0t: read %h returned %h, expected %h",
				$time, address, got, expected));
		assert (bursts == (expectMiss ? 1 : 0))
		else
			failRun($sformatf("Fail at %0t: read %h started %0d bursts, expected %0d",
				$time, address, bursts, expectMiss ? 1 : 0));
		if (expectMiss)
		begin
			assert (lastBurstAddress == lineBase)
			else
				failRun($sformatf("Fail at %0t: burst address %h, expected line base %h",
					$time, lastBurstAddress, lineBase));
		end
		else
		begin
			assert (waitCycles == 2)				// Idle, then dtack in CheckHit
			else
				failRun($sformatf("Fail at %0t: hit on %h took %0d cycles, expected 2",
					$time, address, waitCycles));
		end
		shadowValid[index] = 1'b1;
		shadowTag[index] = tag;
	endtask

	// one CPU write cycle with its own byte strobes
	task automatic writeBytes(input addr_t address, input word_t data, input logic upper,
		input logic lower);
		index_t		index;
		tag_t		tag;
		int			burstsBefore;
		word_t		merged;

		index = address[`CACHE_INDEX_LO +: `CACHE_INDEX_W];
		tag = address[`CACHE_TAG_LO +: `CACHE_TAG_W];
		burstsBefore = burstCount;
		@(posedge Clock);
		#(driveDelay);
		cpuAddress = address;
		cpuDataIn = data;
		cpuWe_L = 1'b0;
		cpuUds_L = !upper;
		cpuLds_L = !lower;
		cpuDramSelect = 1'b1;
		cpuAs_L = 1'b0;
		do
			@(negedge Clock);
		while (cpuDtack_L);							// relayed DRAM acknowledge
		assert (dramAs_L === 1'b0 && dramSelect_L === 1'b0 && dramAddress === address)
		else
			failRun($sformatf("Fail at %0t: write %h drove DRAM address %h, strobe %b, select %b",
				$time, address, dramAddress, dramAs_L, dramSelect_L));
		@(posedge Clock);
		#(driveDelay);
		cpuAs_L = 1'b1;
		cpuDramSelect = 1'b0;
		cpuWe_L = 1'b1;
		cpuUds_L = 1'b1;
		cpuLds_L = 1'b1;
		merged = refMem[address[16:1]];
		if (upper)
			merged[15:8] = data[15:8];
		if (lower)
			merged[7:0] = data[7:0];
		refMem[address[16:1]] = merged;
		assert (dram.mem[address[16:1]] === merged)
		else
			failRun($sformatf("Fail at %0t: write %h left DRAM word %h, expected %h",
				$time, address, dram.mem[address[16:1]], merged));
		assert (burstCount == burstsBefore)
		else
			failRun($sformatf("Fail at %0t: write %h started a burst", $time, address));
		if (shadowValid[index] && shadowTag[index] == tag)
			shadowValid[index] = 1'b0;				// cached copy is now stale
	endtask

	////////////////////////////// directed tests

	task automatic firstReadAfterReset();
		int bursts;
		readWord(makeAddress(9, 3, 3), bursts);		// starts while the sweep runs
		assert (bursts == 1 && lastBurstAddress[3:0] == 4'h0)
		else
			failRun($sformatf("Fail at %0t: first read gave %0d bursts at %h",
				$time, bursts, lastBurstAddress));
	endtask

	task automatic sameLineHit();
		int bursts;
		readWord(makeAddress(9, 3, 6), bursts);
		assert (bursts == 0)
		else
			failRun($sformatf("Fail at %0t: same line read refilled the line", $time));
	endtask

	task automatic conflictingTags();
		int bursts;
		readWord(makeAddress(12, 3, 3), bursts);	// evicts tag 9
		assert (bursts == 1)
		else
			failRun($sformatf("Fail at %0t: new tag on index 3 did not fill", $time));
		readWord(makeAddress(9, 3, 3), bursts);
		assert (bursts == 1)
		else
			failRun($sformatf("Fail at %0t: evicted tag 9 still hit", $time));
	endtask

	task automatic byteAndWordWrites();
		int bursts;
		readWord(makeAddress(18, 5, 2), bursts);
		writeBytes(makeAddress(18, 5, 2), 16'ha5c3, 1'b1, 1'b0);		// upper byte only
		writeBytes(makeAddress(18, 5, 4) | addr_t'(1), 16'h3c96, 1'b0, 1'b1);
		writeBytes(makeAddress(18, 5, 7), 16'h5aa5, 1'b1, 1'b1);
		readWord(makeAddress(18, 5, 2), bursts);
		assert (bursts == 1)
		else
			failRun($sformatf("Fail at %0t: written line was not refilled", $time));
		readWord(makeAddress(18, 5, 4), bursts);
		readWord(makeAddress(18, 5, 7), bursts);
	endtask

	task automatic randomTraffic();
		int			bursts;
		int			choice;
		addr_t		address;

		for (int op = 0; op < randomOps; op++)
		begin
			address = makeAddress(tag_t'($unsigned($random(seed)) % 4 + 1),
				index_t'($unsigned($random(seed)) % 4), wordSel_t'($random(seed)));
			if ($unsigned($random(seed)) % 4 == 0)
			begin
				choice = $unsigned($random(seed)) % 3;	// word, upper or lower
				writeBytes(address, word_t'($random(seed)), choice != 2, choice != 1);
			end
			else
				readWord(address, bursts);
		end
	endtask

	////////////////////////////// run

	initial
	begin : watchdog
		#(timeoutTime);
		failRun($sformatf("watchdog expired at %0t, a CPU bus cycle never completed", $time));
	end

	initial
	begin : runTests
		cpuAddress = '0;
		cpuDataIn = '0;
		cpuAs_L = 1'b1;
		cpuUds_L = 1'b1;
		cpuLds_L = 1'b1;
		cpuWe_L = 1'b1;
		cpuDramSelect = 1'b0;
		shadowValid = '0;
		seed = fillSeed;
		for (int i = 0; i < memWords; i++)
			refMem[i] = word_t'($random(seed));	// same sequence as the DRAM fill
		@(posedge Reset_L);
		firstReadAfterReset();
		sameLineHit();
		conflictingTags();
		byteAndWordWrites();
		randomTraffic();
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/cachePkg.sv
verilog/tagValidStore.sv
verilog/dataStore.sv
verilog/cacheController.sv
verilog/cacheTop.sv
tb/tbClockGen.sv
tb/tbDramModel.sv
tb/cacheTop_tb.sv

//--- Bender.yml
package:
  name: read_cache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cachePkg.sv
      - verilog/tagValidStore.sv
      - verilog/dataStore.sv
      - verilog/cacheController.sv
      - verilog/cacheTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tbClockGen.sv
      - tb/tbDramModel.sv
      - tb/cacheTop_tb.sv
